//--- Bender.yml
package:
  name: floo_router

sources:
  - floo_pkg.sv
  - floo_flit_pkg.sv
  - floo_input_fifo.sv
  - floo_route_select.sv
  - floo_wormhole_arbiter.sv
  - floo_router.sv
  - target: test
    files:
      - tb_floo_router_sva.sv
      - tb_floo_router.sv

//--- floo_flit_pkg.sv
/*
  Flit layout for the mesh router, one packed word per flit.
  From the top: destination x, destination y, last flag, payload.
  There is no source field, so the payload has to identify the sender.
*/

`default_nettype none

package floo_flit_pkg;

  localparam int unsigned PayloadWidth = 16;

  // last flag right above the payload
  localparam int unsigned LastBit = PayloadWidth;

  // destination coordinates, y below x
  localparam int unsigned DstYLsb = LastBit + 1;
  localparam int unsigned DstXLsb = DstYLsb + floo_pkg::CoordWidth;

  // 2 x 3 coordinate bits, 1 last bit, 16 payload bits
  localparam int unsigned FlitWidth = DstXLsb + floo_pkg::CoordWidth;

  typedef logic [FlitWidth-1:0] flit_t;

endpackage

`default_nettype wire

//--- floo_input_fifo.sv
/*
  Register FIFO for one router input with a valid/ready handshake on both sides.
  Depth must be two or more. A pushed flit is visible one cycle later.
  When full, a push is taken only in a cycle that also pops.
*/

`timescale 1ns/1ps
`default_nettype none

module floo_input_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  logic                  valid_i,
  output logic                  ready_o,
  input  floo_flit_pkg::flit_t  data_i,

  output logic                  valid_o,
  input  logic                  ready_i,
  output floo_flit_pkg::flit_t  data_o
);

  floo_flit_pkg::flit_t mem_q [Depth];

  logic [$clog2(Depth)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;

  logic full, push, pop;

  assign full = (int'(count_q) == Depth);

  // head flit straight from the storage
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // a full FIFO still accepts when the head leaves in the same cycle
  assign ready_o = ~full | ready_i;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // wrap explicitly, depth need not be a power of two
        if (int'(wr_ptr_q) == Depth - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (int'(rd_ptr_q) == Depth - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- floo_pkg.sv
/*
  Network-level definitions for the five-port XY mesh router.
  Port indices follow the direction enum and Eject must be the last index.
  Coordinates are unsigned, so the mesh spans at most 8 x 8 routers.
*/

`default_nettype none

package floo_pkg;

  // one port per mesh direction plus the local port
  localparam int unsigned NumPorts = 5;

  localparam int unsigned PortIdxWidth = $clog2(NumPorts);

  // width of one mesh coordinate
  localparam int unsigned CoordWidth = 3;

  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // port indices, shared by inputs and outputs
  typedef enum port_idx_t {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // router position in the mesh, x in the upper bits
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

endpackage

`default_nettype wire

//--- floo_route_select.sv
/*
  Dimension-ordered XY route for one input, purely combinational.
  X is resolved first, then Y. North means a larger y, East a larger x.
  The caller must keep a flit from being routed back out of its own port.
*/

`timescale 1ns/1ps
`default_nettype none

module floo_route_select (
  input  floo_flit_pkg::flit_t        flit_i,
  input  floo_pkg::xy_id_t            xy_id_i,
  output logic [floo_pkg::NumPorts-1:0] route_o
);

  logic [floo_pkg::CoordWidth-1:0] dst_x, dst_y;
  floo_pkg::route_dir_e            dir;

  assign dst_x = flit_i[floo_flit_pkg::DstXLsb +: floo_pkg::CoordWidth];
  assign dst_y = flit_i[floo_flit_pkg::DstYLsb +: floo_pkg::CoordWidth];

  always_comb begin
    if (dst_x > xy_id_i.x) begin
      dir = floo_pkg::East;
    end else if (dst_x < xy_id_i.x) begin
      dir = floo_pkg::West;
    end else if (dst_y > xy_id_i.y) begin
      // same column, move along y
      dir = floo_pkg::North;
    end else if (dst_y < xy_id_i.y) begin
      dir = floo_pkg::South;
    end else begin
      dir = floo_pkg::Eject;
    end
  end

  // exactly one request bit
  always_comb begin
    route_o      = '0;
    route_o[dir] = 1'b1;
  end

endmodule

`default_nettype wire

//--- floo_router.sv
/*
  Five-port XY mesh router, one channel per port, input buffered.
  xy_id_i must stay stable while flits are in flight.
  A flit routed back to its own input is dropped from arbitration and blocks
  that input, so the environment must never send one.
*/

`timescale 1ns/1ps
`default_nettype none

module floo_router (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,

  input  floo_pkg::xy_id_t                              xy_id_i,

  input  logic [floo_pkg::NumPorts-1:0]                 valid_i,
  output logic [floo_pkg::NumPorts-1:0]                 ready_o,
  input  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] data_i,

  output logic [floo_pkg::NumPorts-1:0]                 valid_o,
  input  logic [floo_pkg::NumPorts-1:0]                 ready_i,
  output floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] data_o
);

  // head of each input FIFO
  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] in_data;
  logic [floo_pkg::NumPorts-1:0]                 in_valid, in_ready;

  // route requests, indexed [input][output]
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] route_req;
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] in_out_ready;

  // arbiter side, indexed [output][input]
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] masked_valid, masked_ready;

  for (genvar in_port = 0; in_port < floo_pkg::NumPorts; in_port++) begin : gen_input
    floo_input_fifo #(
      .Depth ( 2 )
    ) i_input_fifo (
      .clk_i    ( clk_i             ),
      .arst_n_i ( arst_n_i          ),
      .valid_i  ( valid_i[in_port]  ),
      .ready_o  ( ready_o[in_port]  ),
      .data_i   ( data_i[in_port]   ),
      .valid_o  ( in_valid[in_port] ),
      .ready_i  ( in_ready[in_port] ),
      .data_o   ( in_data[in_port]  )
    );

    floo_route_select i_route_select (
      .flit_i  ( in_data[in_port]   ),
      .xy_id_i ( xy_id_i            ),
      .route_o ( route_req[in_port] )
    );

    // only the requested arbiter can grant, so this is a plain OR
    assign in_ready[in_port] = |in_out_ready[in_port];
  end

  for (genvar out_port = 0; out_port < floo_pkg::NumPorts; out_port++) begin : gen_output
    for (genvar in_port = 0; in_port < floo_pkg::NumPorts; in_port++) begin : gen_mask
      if (in_port == out_port) begin : gen_no_loopback
        assign masked_valid[out_port][in_port] = 1'b0;
      end else begin : gen_link
        assign masked_valid[out_port][in_port] =
          in_valid[in_port] & route_req[in_port][out_port];
      end
      assign in_out_ready[in_port][out_port] = masked_ready[out_port][in_port];
    end

    // all heads go to every arbiter, the valid mask selects
    floo_wormhole_arbiter i_wormhole_arbiter (
      .clk_i    ( clk_i                  ),
      .arst_n_i ( arst_n_i               ),
      .valid_i  ( masked_valid[out_port] ),
      .ready_o  ( masked_ready[out_port] ),
      .data_i   ( in_data                ),
      .valid_o  ( valid_o[out_port]      ),
      .ready_i  ( ready_i[out_port]      ),
      .data_o   ( data_o[out_port]       )
    );
  end

endmodule

`default_nettype wire

//--- floo_wormhole_arbiter.sv
/*
  Round-robin arbiter for one router output that keeps a packet together.
  A grant is held from the first flit through the flit with the last bit set.
  A stalled grant is also locked, so valid_o and data_o hold under back-pressure.
  Inputs must keep valid high until their flit is taken.
*/

`timescale 1ns/1ps
`default_nettype none

module floo_wormhole_arbiter (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,

  input  logic [floo_pkg::NumPorts-1:0]              valid_i,
  output logic [floo_pkg::NumPorts-1:0]              ready_o,
  input  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] data_i,

  output logic                                       valid_o,
  input  logic                                       ready_i,
  output floo_flit_pkg::flit_t                       data_o
);

  typedef enum logic {
    ArbIdle   = 1'b0,
    ArbLocked = 1'b1
  } arb_state_e;

  arb_state_e          state_q, state_d;
  floo_pkg::port_idx_t lock_idx_q, rr_ptr_q;
  floo_pkg::port_idx_t gnt_idx, gnt_next;
  logic                gnt_found;
  logic                xfer, xfer_last;

  // pick the granted input
  always_comb begin
    int unsigned cand;
    cand      = 0;
    gnt_idx   = lock_idx_q;
    gnt_found = 1'b0;
    if (state_q == ArbLocked) begin
      gnt_found = valid_i[lock_idx_q];
    end else begin
      // first valid input at or after the pointer
      for (int unsigned off = 0; off < floo_pkg::NumPorts; off++) begin
        cand = int'(rr_ptr_q) + off;
        if (cand >= floo_pkg::NumPorts) begin
          cand = cand - floo_pkg::NumPorts;
        end
        if (!gnt_found && valid_i[cand]) begin
          gnt_found = 1'b1;
          gnt_idx   = floo_pkg::port_idx_t'(cand);
        end
      end
    end
  end

  assign valid_o = gnt_found;
  assign data_o  = data_i[gnt_idx];

  always_comb begin
    ready_o          = '0;
    ready_o[gnt_idx] = gnt_found & ready_i;
  end

  assign xfer      = valid_o & ready_i;
  assign xfer_last = xfer & data_o[floo_flit_pkg::LastBit];

  // pointer goes just past the input that finished a packet
  assign gnt_next = (int'(gnt_idx) == floo_pkg::NumPorts - 1) ? '0 : gnt_idx + 1'b1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ArbIdle: begin
        // lock on a body flit, or on any flit left waiting
        if ((xfer && !xfer_last) || (valid_o && !ready_i)) begin
          state_d = ArbLocked;
        end
      end
      ArbLocked: begin
        if (xfer_last) begin
          state_d = ArbIdle;
        end
      end
      default: state_d = ArbIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ArbIdle;
      lock_idx_q <= '0;
      rr_ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ArbIdle && state_d == ArbLocked) begin
        lock_idx_q <= gnt_idx;
      end
      if (xfer_last) begin
        rr_ptr_q <= gnt_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_floo_router.sv
/*
  Random traffic testbench for the mesh router placed at (3,3).
  Outputs are sampled on the falling edge and inputs driven on the rising edge.
  The payload carries the source port in its top bits and a sequence number below.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_floo_router;

  localparam int NP        = floo_pkg::NumPorts;
  localparam int ClkPeriod = 40;
  localparam int NumPkts   = 40;
  localparam int MaxLen    = 4;
  localparam int MyX       = 3;
  localparam int MyY       = 3;
  localparam int SrcWidth  = 3;
  localparam int SeqWidth  = floo_flit_pkg::PayloadWidth - SrcWidth;
  localparam int TimeoutNs = NumPkts * MaxLen * NP * ClkPeriod * 4;

  logic                          clk_i;
  logic                          arst_n_i;
  floo_pkg::xy_id_t              xy_id_i;
  logic [NP-1:0]                 valid_i, ready_o, valid_o, ready_i;
  floo_flit_pkg::flit_t [NP-1:0] data_i, data_o;

  integer seed = 32'h2e425df6;

  // per source stimulus, and expected flits per source and output
  floo_flit_pkg::flit_t stim_q [NP][$];
  floo_flit_pkg::flit_t model_q [NP][NP][$];
  int                   stim_idx [NP];
  logic [NP-1:0]        in_fire = '0;
  logic [NP-1:0]        lock_on = '0;
  int                   lock_src [NP];

  int total_flits = 0, sent_cnt = 0, recv_cnt = 0;
  int chk_reset = 0, err_reset = 0, chk_route = 0, err_route = 0;
  int chk_order = 0, err_order = 0, chk_worm = 0, err_worm = 0;
  int chk_bp = 0, err_bp = 0;

  floo_router dut_i (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .xy_id_i  ( xy_id_i  ),
    .valid_i  ( valid_i  ),
    .ready_o  ( ready_o  ),
    .data_i   ( data_i   ),
    .valid_o  ( valid_o  ),
    .ready_i  ( ready_i  ),
    .data_o   ( data_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // XY rule, x first, then y, north is larger y
  function automatic int xy_route(floo_flit_pkg::flit_t f);
    int dx, dy;
    dx = f[floo_flit_pkg::DstXLsb +: floo_pkg::CoordWidth];
    dy = f[floo_flit_pkg::DstYLsb +: floo_pkg::CoordWidth];
    if (dx > MyX) return int'(floo_pkg::East);
    if (dx < MyX) return int'(floo_pkg::West);
    if (dy > MyY) return int'(floo_pkg::North);
    if (dy < MyY) return int'(floo_pkg::South);
    return int'(floo_pkg::Eject);
  endfunction

  function automatic floo_flit_pkg::flit_t make_flit(int x, int y, logic last, int src, int seq);
    floo_flit_pkg::flit_t f;
    int                   payload;
    payload = (src << SeqWidth) | (seq % (1 << SeqWidth));
    f = '0;
    f[floo_flit_pkg::DstXLsb +: floo_pkg::CoordWidth] = x[floo_pkg::CoordWidth-1:0];
    f[floo_flit_pkg::DstYLsb +: floo_pkg::CoordWidth] = y[floo_pkg::CoordWidth-1:0];
    f[floo_flit_pkg::LastBit] = last;
    f[floo_flit_pkg::PayloadWidth-1:0] = payload[floo_flit_pkg::PayloadWidth-1:0];
    return f;
  endfunction

  task automatic build_stimulus();
    int len, x, y, seq;
    for (int p = 0; p < NP; p++) begin
      seq = 0;
      stim_idx[p] = 0;
      for (int n = 0; n < NumPkts; n++) begin
        len = 1 + {$random(seed)} % MaxLen;
        // no packet may leave through the port it came in on
        do begin
          x = {$random(seed)} % (1 << floo_pkg::CoordWidth);
          y = {$random(seed)} % (1 << floo_pkg::CoordWidth);
        end while (xy_route(make_flit(x, y, 1'b0, p, 0)) == p);
        for (int i = 0; i < len; i++) begin
          stim_q[p].push_back(make_flit(x, y, i == len - 1, p, seq));
          seq++;
        end
      end
      total_flits += stim_q[p].size();
    end
  endtask

  // called on the rising edge, in_fire comes from the falling edge before
  task automatic drive_inputs();
    for (int p = 0; p < NP; p++) begin
      if (!valid_i[p] || in_fire[p]) begin
        if (stim_idx[p] < stim_q[p].size() && ({$random(seed)} % 4 != 0)) begin
          data_i[p]  <= stim_q[p][stim_idx[p]];
          valid_i[p] <= 1'b1;
          stim_idx[p]++;
        end else begin
          valid_i[p] <= 1'b0;
        end
      end
      // stalls last a single cycle
      if (!ready_i[p]) begin
        ready_i[p] <= 1'b1;
      end else begin
        ready_i[p] <= ({$random(seed)} % 5 != 0);
      end
    end
  endtask

  task automatic note_input(int src, floo_flit_pkg::flit_t f);
    model_q[src][xy_route(f)].push_back(f);
    sent_cnt++;
  endtask

  task automatic check_output(int out, floo_flit_pkg::flit_t f);
    int                   src;
    floo_flit_pkg::flit_t exp;
    src = f[floo_flit_pkg::PayloadWidth-1 -: SrcWidth];
    recv_cnt++;
    chk_route++;
    assert (xy_route(f) == out) else begin
      err_route++;
      $display("error routing: expected output %0d, actual output %0d", xy_route(f), out);
    end
    chk_order++;
    assert (src < NP && model_q[src][out].size() > 0) else begin
      err_order++;
      $display("order: flit %h left output %0d without being sent to it", f, out);
    end
    if (src < NP && model_q[src][out].size() > 0) begin
      exp = model_q[src][out].pop_front();
      chk_order++;
      assert (f == exp) else begin
        err_order++;
        $display("error order: expected %h, actual %h on output %0d", exp, f, out);
      end
    end
    // an open packet owns the output until its last flit
    if (lock_on[out]) begin
      chk_worm++;
      assert (src == lock_src[out]) else begin
        err_worm++;
        $display("error wormhole: expected source %0d, actual source %0d on output %0d",
                 lock_src[out], src, out);
      end
    end
    lock_on[out]  = !f[floo_flit_pkg::LastBit];
    lock_src[out] = src;
  endtask

  task automatic print_test_result(string name, int checks, int errs);
    $display("test %-12s %0d checks, %0d errors", name, checks, errs);
  endtask

  initial begin
    logic [NP-1:0] out_fire;
    int            drain;
    int            errs;
    drain     = 0;
    arst_n_i  = 1'b1;
    valid_i   = '0;
    ready_i   = '1;
    data_i    = '0;
    xy_id_i.x = MyX;
    xy_id_i.y = MyY;
    build_stimulus();

    @(posedge clk_i);
    arst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;

    @(negedge clk_i);
    chk_reset += 2;
    assert (ready_o == '1) else begin
      err_reset++;
      $display("error reset: expected ready_o %b, actual %b", {NP{1'b1}}, ready_o);
    end
    assert (valid_o == '0) else begin
      err_reset++;
      $display("error reset: expected valid_o %b, actual %b", {NP{1'b0}}, valid_o);
    end
    print_test_result("reset", chk_reset, err_reset);

    // traffic, then a few idle cycles to catch duplicates
    while (drain < 5) begin
      @(posedge clk_i);
      drive_inputs();
      @(negedge clk_i);
      in_fire  = valid_i & ready_o;
      out_fire = valid_o & ready_i;
      for (int p = 0; p < NP; p++) begin
        if (in_fire[p]) note_input(p, data_i[p]);
      end
      for (int k = 0; k < NP; k++) begin
        if (out_fire[k]) check_output(k, data_o[k]);
      end
      if (recv_cnt >= total_flits) drain++;
    end

    chk_bp += 2;
    assert (sent_cnt == total_flits && recv_cnt == total_flits) else begin
      err_bp++;
      $display("error backpressure: expected %0d flits, actual %0d sent and %0d received",
               total_flits, sent_cnt, recv_cnt);
    end
    assert (valid_o == '0) else begin
      err_bp++;
      $display("backpressure: outputs still valid after all traffic drained");
    end
    for (int s = 0; s < NP; s++) begin
      for (int k = 0; k < NP; k++) begin
        chk_bp++;
        assert (model_q[s][k].size() == 0) else begin
          err_bp++;
          $display("error backpressure: expected 0 flits, actual %0d left from %0d to %0d",
                   model_q[s][k].size(), s, k);
        end
      end
    end
    print_test_result("routing", chk_route, err_route);
    print_test_result("order", chk_order, err_order);
    print_test_result("wormhole", chk_worm, err_worm);
    print_test_result("backpressure", chk_bp, err_bp);

    errs = err_reset + err_route + err_order + err_worm + err_bp;
    $display("summary: %0d checks, %0d errors, %0d assertion failures",
             chk_reset + chk_route + chk_order + chk_worm + chk_bp, errs,
             dut_i.i_router_sva.fail_count);
    if (errs == 0 && dut_i.i_router_sva.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // every flit of every port, four times over
  initial begin
    #(TimeoutNs);
    $display("timeout: traffic did not drain within %0d ns", TimeoutNs);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_floo_router_sva.sv
/*
  Handshake assertions for the router ports, bound into every floo_router.
  fail_count holds the number of failed assertions so far.
*/

`timescale 1ns/1ps
`default_nettype none

module floo_router_sva (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic [floo_pkg::NumPorts-1:0]                 valid_i,
  input  logic [floo_pkg::NumPorts-1:0]                 ready_o,
  input  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] data_i,
  input  logic [floo_pkg::NumPorts-1:0]                 valid_o,
  input  logic [floo_pkg::NumPorts-1:0]                 ready_i,
  input  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0] data_o
);

  int unsigned fail_count = 0;

  for (genvar p = 0; p < floo_pkg::NumPorts; p++) begin : gen_port
    // a stalled output keeps its flit
    out_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_o[p] && !ready_i[p] |=> valid_o[p] && $stable(data_o[p]))
    else begin
      fail_count++;
      $error("output %0d changed while stalled", p);
    end

    // sender holds a refused flit
    in_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_i[p] && !ready_o[p] |=> valid_i[p] && $stable(data_i[p]))
    else begin
      fail_count++;
      $error("input %0d changed while refused", p);
    end
  end

  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> valid_o == '0)
  else begin
    fail_count++;
    $error("valid_o high during reset");
  end

endmodule

bind floo_router floo_router_sva i_router_sva (.*);

`default_nettype wire

//--- verilog.f
floo_pkg.sv
floo_flit_pkg.sv
floo_input_fifo.sv
floo_route_select.sv
floo_wormhole_arbiter.sv
floo_router.sv
tb_floo_router_sva.sv
tb_floo_router.sv
